/* hw/pca_config.svh */
// Fixed-point format, mixing matrix constants and reset weight
// Wishbone register byte offsets
`ifndef PCA_CONFIG_SVH
`define PCA_CONFIG_SVH

`define PCA_FRAC        16            // Fraction bits of 16.16

// Mixing matrix, x1 = a11*s1 + a12*s2, x2 = a21*s1 - a22*s2
`define PCA_A11         32'h0000C000  // 0.75
`define PCA_A12         32'h00018000  // 1.5
`define PCA_A21         32'h00008000  // 0.5
`define PCA_A22         32'h00005555  // 0.333333

`define PCA_W_INIT      32'h00008000  // Eigenvector start value 0.5

// Register map
`define PCA_REG_S1      8'h00         // Source sample 1
`define PCA_REG_S2      8'h04         // Source sample 2
`define PCA_REG_MU1     8'h08         // Learning rate PC1
`define PCA_REG_MU2     8'h0C         // Learning rate PC2
`define PCA_REG_CTRL    8'h10         // Bit 0 starts a step
`define PCA_REG_STATUS  8'h14         // Busy at bit 16, count below
`define PCA_REG_X1      8'h20
`define PCA_REG_X2      8'h24
`define PCA_REG_W11     8'h28
`define PCA_REG_W12     8'h2C
`define PCA_REG_W21     8'h30
`define PCA_REG_W22     8'h34
`define PCA_REG_Y1      8'h38
`define PCA_REG_Y2      8'h3C

`endif

/* hw/pca_gha_execute.sv */
// Mixing matrix and Sanger GHA datapath
// Stage A mixes the sources, stage B forms y and updates the weights
`timescale 1ns/1ns
`include "pca_config.svh"

module pca_gha_execute (
  input logic          clk,
  input logic          reset,
  pca_step_if.sink     step_if,
  pca_state_if.source  state_if
);
  import pca_pkg::*;

  // 16.16 multiply, full product then truncate
  function automatic fix_t fmul(input fix_t a, input fix_t b);
    prod_t p;
    p = a * b;
    return fix_t'(p >>> `PCA_FRAC);
  endfunction

  fix_t x1_a, x2_a;       // Mixed sample
  fix_t mu1_a, mu2_a;     // Rates travelling with it
  logic valid_a;          // Stage A holds a fresh sample

  fix_t w11, w12, w21, w22;              // Eigenvectors
  fix_t y1, y2;                          // Component outputs
  fix_t h11, h12, h21, h22;              // Reconstruction terms
  fix_t g1, g2;                          // mu * y
  fix_t w11_n, w12_n, w21_n, w22_n;      // Updated weights

  //**********************************************************
  // Stage A, mixing
  //**********************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      valid_a <= 1'b0;
    else
      valid_a <= step_if.step;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      x1_a  <= '0;
      x2_a  <= '0;
      mu1_a <= '0;
      mu2_a <= '0;
    end else if (step_if.step) begin
      x1_a  <= fmul(`PCA_A11, step_if.s1) + fmul(`PCA_A12, step_if.s2);
      x2_a  <= fmul(`PCA_A21, step_if.s1) - fmul(`PCA_A22, step_if.s2);
      mu1_a <= step_if.mu1;
      mu2_a <= step_if.mu2;
    end
  end

  //**********************************************************
  // Stage B, Sanger GHA
  //**********************************************************
  always_comb begin
    // Projections onto the current eigenvectors
    y1  = fmul(x1_a, w11) + fmul(x2_a, w12);
    y2  = fmul(x1_a, w21) + fmul(x2_a, w22);
    h11 = fmul(w11, y1);   // PC1 reconstruction
    h12 = fmul(w12, y1);
    h21 = fmul(w21, y2);   // PC2 reconstruction
    h22 = fmul(w22, y2);
    g1  = fmul(mu1_a, y1);
    g2  = fmul(mu2_a, y2);
    // First PC sees only its own reconstruction
    w11_n = w11 + fmul(g1, x1_a - h11);
    w12_n = w12 + fmul(g1, x2_a - h12);
    // Second PC also removes the first one
    w21_n = w21 + fmul(g2, x1_a - h11 - h21);
    w22_n = w22 + fmul(g2, x2_a - h12 - h22);
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      w11 <= `PCA_W_INIT;
      w12 <= `PCA_W_INIT;
      w21 <= `PCA_W_INIT;
      w22 <= `PCA_W_INIT;
    end else if (valid_a) begin
      w11 <= w11_n;
      w12 <= w12_n;
      w21 <= w21_n;
      w22 <= w22_n;
    end
  end

  // Published state, y and weights taken at the same edge downstream
  assign state_if.x1   = x1_a;
  assign state_if.x2   = x2_a;
  assign state_if.w11  = w11_n;
  assign state_if.w12  = w12_n;
  assign state_if.w21  = w21_n;
  assign state_if.w22  = w22_n;
  assign state_if.y1   = y1;
  assign state_if.y2   = y2;
  assign state_if.done = valid_a;

endmodule

/* hw/pca_if.sv */
// Step interface from the register decoder to the datapath
// State interface from the datapath to the result block
`timescale 1ns/1ns

interface pca_step_if;
  import pca_pkg::*;

  fix_t s1;    // Source samples
  fix_t s2;
  fix_t mu1;   // Learning rates
  fix_t mu2;
  logic step;  // One-cycle start pulse

  modport source (output s1, output s2, output mu1, output mu2, output step);
  modport sink   (input  s1, input  s2, input  mu1, input  mu2, input  step);
endinterface

interface pca_state_if;
  import pca_pkg::*;

  fix_t x1;    // Mixed inputs
  fix_t x2;
  fix_t w11;   // Eigenvector weights after update
  fix_t w12;
  fix_t w21;
  fix_t w22;
  fix_t y1;    // Component outputs
  fix_t y2;
  logic done;  // New sample on the lines

  modport source (
    output x1, output x2, output w11, output w12,
    output w21, output w22, output y1, output y2, output done
  );
  modport sink (
    input x1, input x2, input w11, input w12,
    input w21, input w22, input y1, input y2, input done
  );
endinterface

/* hw/pca_pkg.sv */
// Shared types of the PCA engine
// Fixed-point and Wishbone words, sample counter, readback select

package pca_pkg;

  //**********************************************************
  // Data words
  //**********************************************************
  typedef logic signed [31:0] fix_t;     // 16.16 value
  typedef logic signed [63:0] prod_t;    // Full product before shift

  //**********************************************************
  // Bus and status words
  //**********************************************************
  typedef logic [7:0]  wb_adr_t;         // Byte address
  typedef logic [31:0] wb_dat_t;         // Data word
  typedef logic [15:0] count_t;          // Finished samples

  // Readback words held by the result block
  typedef enum logic [3:0] {
    SEL_X1,
    SEL_X2,
    SEL_W11,
    SEL_W12,
    SEL_W21,
    SEL_W22,
    SEL_Y1,
    SEL_Y2,
    SEL_STATUS
  } res_sel_t;

endpackage

/* hw/pca_result.sv */
// Published PCA state with readback select
// Sample counter and busy flag
`timescale 1ns/1ns
`include "pca_config.svh"

module pca_result (
  input  logic              clk,
  input  logic              reset,
  pca_state_if.sink         state_if,
  input  logic              step,      // Start pulse from the decoder
  input  pca_pkg::res_sel_t res_sel,
  output pca_pkg::wb_dat_t  res_data
);
  import pca_pkg::*;

  fix_t   x1_q, x2_q;
  fix_t   w11_q, w12_q, w21_q, w22_q;
  fix_t   y1_q, y2_q;
  count_t count;      // Finished samples, wraps
  logic   busy;

  //**********************************************************
  // Capture on done
  //**********************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      x1_q  <= '0;
      x2_q  <= '0;
      w11_q <= `PCA_W_INIT;
      w12_q <= `PCA_W_INIT;
      w21_q <= `PCA_W_INIT;
      w22_q <= `PCA_W_INIT;
      y1_q  <= '0;
      y2_q  <= '0;
      count <= '0;
    end else if (state_if.done) begin
      x1_q  <= state_if.x1;
      x2_q  <= state_if.x2;
      w11_q <= state_if.w11;
      w12_q <= state_if.w12;
      w21_q <= state_if.w21;
      w22_q <= state_if.w22;
      y1_q  <= state_if.y1;
      y2_q  <= state_if.y2;
      count <= count + 1'b1;
    end
  end

  // Step wins over done, a new sample is then in stage A
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      busy <= 1'b0;
    else if (step)
      busy <= 1'b1;
    else if (state_if.done)
      busy <= 1'b0;
  end

  // Readback word
  always_comb begin
    case (res_sel)
      SEL_X1:     res_data = x1_q;
      SEL_X2:     res_data = x2_q;
      SEL_W11:    res_data = w11_q;
      SEL_W12:    res_data = w12_q;
      SEL_W21:    res_data = w21_q;
      SEL_W22:    res_data = w22_q;
      SEL_Y1:     res_data = y1_q;
      SEL_Y2:     res_data = y2_q;
      SEL_STATUS: res_data = {15'd0, busy, count};
      default:    res_data = '0;
    endcase
  end

endmodule

/* hw/pca_top.sv */
// Top level of the streaming two-component PCA engine
// Wishbone decoder, GHA datapath and result block
`timescale 1ns/1ns

module pca_top (
  input  logic             clk,
  input  logic             reset,
  input  pca_pkg::wb_adr_t wb_adr,
  input  pca_pkg::wb_dat_t wb_dat_w,
  output pca_pkg::wb_dat_t wb_dat_r,
  input  logic             wb_we,
  input  logic             wb_cyc,
  input  logic             wb_stb,
  output logic             wb_ack
);
  import pca_pkg::*;

  pca_step_if  step_if ();   // Decoder to datapath
  pca_state_if state_if ();  // Datapath to result

  res_sel_t res_sel;         // Readback word select
  wb_dat_t  res_data;

  //**********************************************************
  // Bus side
  //**********************************************************
  pca_wb_decode u_decode (
    .clk      (clk),
    .reset    (reset),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_we    (wb_we),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r),
    .step_if  (step_if.source),
    .res_sel  (res_sel),
    .res_data (res_data)
  );

  //**********************************************************
  // Datapath and published state
  //**********************************************************
  pca_gha_execute u_execute (
    .clk      (clk),
    .reset    (reset),
    .step_if  (step_if.sink),
    .state_if (state_if.source)
  );

  pca_result u_result (
    .clk      (clk),
    .reset    (reset),
    .state_if (state_if.sink),
    .step     (step_if.step),   // Sets busy
    .res_sel  (res_sel),
    .res_data (res_data)
  );

endmodule

/* hw/pca_wb_decode.sv */
// Wishbone classic slave of the PCA engine
// Input registers, step command from CTRL, read data path
`timescale 1ns/1ns
`include "pca_config.svh"

module pca_wb_decode (
  input  logic              clk,
  input  logic              reset,
  input  pca_pkg::wb_adr_t  wb_adr,
  input  pca_pkg::wb_dat_t  wb_dat_w,
  input  logic              wb_we,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  output logic              wb_ack,
  output pca_pkg::wb_dat_t  wb_dat_r,
  pca_step_if.source        step_if,
  output pca_pkg::res_sel_t res_sel,   // Result word wanted
  input  pca_pkg::wb_dat_t  res_data   // Result word returned
);
  import pca_pkg::*;

  logic    acc;      // New access, ack not yet given
  logic    wr;
  wb_dat_t rd_word;  // Read data before the ack register

  assign acc = wb_cyc & wb_stb & ~wb_ack;
  assign wr  = acc & wb_we;

  //**********************************************************
  // Address to result select
  //**********************************************************
  always_comb begin
    case (wb_adr)
      `PCA_REG_X1:  res_sel = SEL_X1;
      `PCA_REG_X2:  res_sel = SEL_X2;
      `PCA_REG_W11: res_sel = SEL_W11;
      `PCA_REG_W12: res_sel = SEL_W12;
      `PCA_REG_W21: res_sel = SEL_W21;
      `PCA_REG_W22: res_sel = SEL_W22;
      `PCA_REG_Y1:  res_sel = SEL_Y1;
      `PCA_REG_Y2:  res_sel = SEL_Y2;
      default:      res_sel = SEL_STATUS;  // STATUS and don't-care
    endcase
  end

  // Read mux, own registers first
  always_comb begin
    case (wb_adr)
      `PCA_REG_S1:     rd_word = step_if.s1;
      `PCA_REG_S2:     rd_word = step_if.s2;
      `PCA_REG_MU1:    rd_word = step_if.mu1;
      `PCA_REG_MU2:    rd_word = step_if.mu2;
      `PCA_REG_STATUS,
      `PCA_REG_X1,
      `PCA_REG_X2,
      `PCA_REG_W11,
      `PCA_REG_W12,
      `PCA_REG_W21,
      `PCA_REG_W22,
      `PCA_REG_Y1,
      `PCA_REG_Y2:     rd_word = res_data;
      default:         rd_word = '0;       // CTRL and holes read 0
    endcase
  end

  //**********************************************************
  // Ack, step pulse and input registers
  //**********************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_ack       <= 1'b0;
      wb_dat_r     <= '0;
      step_if.step <= 1'b0;
      step_if.s1   <= '0;
      step_if.s2   <= '0;
      step_if.mu1  <= '0;
      step_if.mu2  <= '0;
    end else begin
      wb_ack       <= acc;  // One wait cycle, one ack cycle
      step_if.step <= wr && (wb_adr == `PCA_REG_CTRL) && wb_dat_w[0];
      if (acc && !wb_we)
        wb_dat_r <= rd_word;
      if (wr) begin
        case (wb_adr)
          `PCA_REG_S1:  step_if.s1  <= wb_dat_w;
          `PCA_REG_S2:  step_if.s2  <= wb_dat_w;
          `PCA_REG_MU1: step_if.mu1 <= wb_dat_w;
          `PCA_REG_MU2: step_if.mu2 <= wb_dat_w;
          default: ;                         // Ignored
        endcase
      end
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the PCA engine testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f \
  --top-module pca_tb \
  -o Vpca_tb

./obj_dir/Vpca_tb | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

/* tests/pca_asserts.sv */
// Concurrent checks on the Wishbone handshake and the step timing
// Bound into the PCA top level
`timescale 1ns/1ns
`include "pca_config.svh"

module pca_asserts (
  input logic             clk,
  input logic             reset,
  input pca_pkg::wb_adr_t wb_adr,
  input pca_pkg::wb_dat_t wb_dat_w,
  input logic             wb_we,
  input logic             wb_cyc,
  input logic             wb_stb,
  input logic             wb_ack,
  input logic             done
);

  logic start_req;  // CTRL write with bit 0, about to be taken

  assign start_req = wb_cyc && wb_stb && !wb_ack && wb_we
                     && (wb_adr == `PCA_REG_CTRL) && wb_dat_w[0];

  //**********************************************************
  // Bus handshake
  //**********************************************************
  ack_single_cycle: assert property (
    @(posedge clk) disable iff (reset) wb_ack |=> !wb_ack
  ) else $error("wb_ack held for more than one cycle");

  // Ack only answers a strobed cycle
  ack_after_request: assert property (
    @(posedge clk) disable iff (reset) wb_ack |-> $past(wb_cyc && wb_stb)
  ) else $error("wb_ack without a preceding cyc and stb");

  //**********************************************************
  // Datapath timing
  //**********************************************************
  // Step pulse in the ack cycle, done in the one after
  done_after_step: assert property (
    @(posedge clk) disable iff (reset) start_req |-> ##2 done
  ) else $error("done missing two cycles after a CTRL start write");

endmodule

bind pca_top pca_asserts u_asserts (
  .clk      (clk),
  .reset    (reset),
  .wb_adr   (wb_adr),
  .wb_dat_w (wb_dat_w),
  .wb_we    (wb_we),
  .wb_cyc   (wb_cyc),
  .wb_stb   (wb_stb),
  .wb_ack   (wb_ack),
  .done     (state_if.done)
);

/* tests/pca_patterns.hex */
// Columns per line: s1 s2 mu1 mu2 x1 x2 y1 y2 w11 w12 w21 w22
// All words are 32-bit signed 16.16, weights carry over between lines
00010000 00000000 00008000 00004000 0000C000 00008000 0000A000 0000A000 0000A300 00008F00 00008500 00007B00
00020000 00000000 00000000 00000000 00018000 00010000 00018380 00014280 0000A300 00008F00 00008500 00007B00
00000000 00030000 00000000 00000000 00048000 FFFF0001 00024E80 0001DB80 0000A300 00008F00 00008500 00007B00
00010000 00000000 00004000 00004000 0000C000 00008000 0000C1C0 0000A140 0000AFFC 000092BD 0000829D 000071EA
00000000 00000000 00008000 00008000 00000000 00000000 00000000 00000000 0000AFFC 000092BD 0000829D 000071EA
00010000 00000000 00000000 00000000 0000C000 00008000 0000CD5B 00009AEA 0000AFFC 000092BD 0000829D 000071EA
00020000 00030000 00000000 00000000 00060000 00000001 00041FE8 00030FAE 0000AFFC 000092BD 0000829D 000071EA
FFFF0000 00000000 00000000 00000000 FFFF4000 FFFF8000 FFFF32A4 FFFF6515 0000AFFC 000092BD 0000829D 000071EA

/* tests/pca_tb.sv */
// Testbench of the PCA engine
// Wishbone access tasks, pattern replay, value check and timeout
`timescale 1ns/1ns
`include "pca_config.svh"

module pca_tb;
  import pca_pkg::*;

  localparam int NUM_SAMPLES = 8;
  localparam int WORDS       = 12;          // Words per pattern line
  localparam int MAX_CYCLES  = 1000;        // 8 samples, about 60 cycles each

  logic    clk;
  logic    reset;
  wb_adr_t wb_adr;
  wb_dat_t wb_dat_w;
  wb_dat_t wb_dat_r;
  logic    wb_we;
  logic    wb_cyc;
  logic    wb_stb;
  logic    wb_ack;

  logic [31:0] pat [0:NUM_SAMPLES*WORDS-1];
  int          cycles = 0;

  pca_top dut (
    .clk      (clk),
    .reset    (reset),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_we    (wb_we),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack)
  );

  //************************************************************
  // Clock and cycle limit
  //************************************************************
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                  // 8 ns period
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $fatal(1);
    end
  end

  //************************************************************
  // Helpers
  //************************************************************
  task automatic check(input string msg, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, msg, got, exp);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  // Random 0 to 3 idle cycles, stays 1 ns after the edge
  task automatic idle_gap();
    int n;
    n = $urandom % 4;
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic bus_write(input wb_adr_t adr, input wb_dat_t dat);
    wb_adr   = adr;
    wb_dat_w = dat;
    wb_we    = 1'b1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!wb_ack);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_read(input wb_adr_t adr, output wb_dat_t dat);
    wb_adr = adr;
    wb_we  = 1'b0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!wb_ack);
    dat    = wb_dat_r;                      // Registered with the ack
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // Poll STATUS until the busy bit drops
  task automatic wait_idle();
    wb_dat_t st;
    do begin
      idle_gap();
      bus_read(`PCA_REG_STATUS, st);
    end while (st[16]);
  endtask

  //************************************************************
  // Main sequence
  //************************************************************
  initial begin
    wb_adr_t     res_adr [0:7];
    string       res_name [0:7];
    wb_dat_t     rd;
    wb_dat_t     exp_word;
    wb_dat_t     exp_w [0:3];
    logic        frozen;
    int          base;

    wb_adr   = '0;
    wb_dat_w = '0;
    wb_we    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    reset    = 1'b1;
    void'($urandom(32'h85a6_1bf5));

    // Result words in pattern column order
    res_adr[0]  = `PCA_REG_X1;
    res_name[0] = "x1";
    res_adr[1]  = `PCA_REG_X2;
    res_name[1] = "x2";
    res_adr[2]  = `PCA_REG_Y1;
    res_name[2] = "y1";
    res_adr[3]  = `PCA_REG_Y2;
    res_name[3] = "y2";
    res_adr[4]  = `PCA_REG_W11;
    res_name[4] = "w11";
    res_adr[5]  = `PCA_REG_W12;
    res_name[5] = "w12";
    res_adr[6]  = `PCA_REG_W21;
    res_name[6] = "w21";
    res_adr[7]  = `PCA_REG_W22;
    res_name[7] = "w22";

    $readmemh("tests/pca_patterns.hex", pat);

    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    // Reset state, weights at 0.5 and the rest 0
    for (int i = 0; i < 8; i++) begin
      bus_read(res_adr[i], rd);
      check({"reset ", res_name[i]}, rd, (i >= 4) ? `PCA_W_INIT : 32'h0);
    end
    bus_read(`PCA_REG_STATUS, rd);
    check("reset status", rd, 32'h0);
    for (int i = 0; i < 4; i++)
      exp_w[i] = `PCA_W_INIT;

    // Input registers read back
    bus_write(`PCA_REG_S1, 32'h1234_5678);
    bus_write(`PCA_REG_S2, 32'hFEDC_BA98);
    bus_write(`PCA_REG_MU1, 32'h0000_0100);
    bus_write(`PCA_REG_MU2, 32'h8000_0001);
    bus_read(`PCA_REG_S1, rd);
    check("s1 readback", rd, 32'h1234_5678);
    bus_read(`PCA_REG_S2, rd);
    check("s2 readback", rd, 32'hFEDC_BA98);
    bus_read(`PCA_REG_MU1, rd);
    check("mu1 readback", rd, 32'h0000_0100);
    bus_read(`PCA_REG_MU2, rd);
    check("mu2 readback", rd, 32'h8000_0001);

    // Hole in the map acks, ignores writes, reads 0
    bus_write(8'h18, 32'hDEAD_BEEF);
    bus_read(8'h18, rd);
    check("unmapped read", rd, 32'h0);

    //**********************************************************
    // Pattern replay, weights run on from sample to sample
    //**********************************************************
    for (int n = 0; n < NUM_SAMPLES; n++) begin
      base   = n * WORDS;
      frozen = (pat[base + 2] == 32'h0) && (pat[base + 3] == 32'h0);
      idle_gap();
      bus_write(`PCA_REG_S1, pat[base]);
      bus_write(`PCA_REG_S2, pat[base + 1]);
      idle_gap();
      bus_write(`PCA_REG_MU1, pat[base + 2]);
      bus_write(`PCA_REG_MU2, pat[base + 3]);
      idle_gap();
      bus_write(`PCA_REG_CTRL, 32'h1);        // Step
      wait_idle();

      for (int i = 0; i < 8; i++) begin
        idle_gap();
        bus_read(res_adr[i], rd);
        exp_word = pat[base + 4 + i];
        // Zero rates keep the weights of the sample before
        if (i >= 4 && frozen)
          exp_word = exp_w[i - 4];
        check($sformatf("sample %0d %s", n, res_name[i]), rd, exp_word);
        if (i >= 4)
          exp_w[i - 4] = exp_word;
      end

      bus_read(`PCA_REG_STATUS, rd);
      check($sformatf("sample %0d status", n), rd, 32'(n + 1));
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hw
hw/pca_pkg.sv
hw/pca_if.sv
hw/pca_wb_decode.sv
hw/pca_gha_execute.sv
hw/pca_result.sv
hw/pca_top.sv
tests/pca_asserts.sv
tests/pca_tb.sv
